//--- hdl/ppu_pkg.sv
package ppu_pkg;

  // ========================================
  // Configuration word
  // ========================================

  localparam int CFG_W = 17;                 // Static level word from the controller

  typedef logic [CFG_W-1:0] cfg_word_t;

  // Vertical scale factor, drives scanline thickness
  localparam int CFG_VSCALE_LSB     = 0;
  localparam int CFG_VSCALE_W       = 5;

  // 240p scanline settings
  localparam int CFG_SL240_STR_LSB  = 5;
  localparam int CFG_SL240_STR_W    = 4;
  localparam int CFG_SL240_EN_LSB   = 9;
  localparam int CFG_SL240_EN_W     = 1;

  // 480i scanline settings
  localparam int CFG_SL480_STR_LSB  = 10;
  localparam int CFG_SL480_STR_W    = 4;
  localparam int CFG_SL480_EN_LSB   = 14;
  localparam int CFG_SL480_EN_W     = 1;
  localparam int CFG_SL480_LINK_LSB = 15;    // 480i takes strength from 240p field
  localparam int CFG_SL480_LINK_W   = 1;

  // Output range
  localparam int CFG_LIMRGB_LSB     = 16;
  localparam int CFG_LIMRGB_W       = 1;

  // ========================================
  // Scanline constants
  // ========================================

  localparam logic [4:0] VSCALE_THIN_MAX = 5'd6;   // Below 3.5x
  localparam logic [4:0] VSCALE_MID_MAX  = 5'd14;  // Below 5.5x

  localparam int SL_THICK_W = 2;             // Thickness 0..2
  localparam int SL_STR_W   = 8;             // Expanded strength 15..255

  // ========================================
  // Limited range constants
  // ========================================

  // 8-bit reference, 0..255 becomes 16..235
  localparam logic [7:0] LIMIT_COEFF  = 8'd220;
  localparam logic [7:0] LIMIT_OFFSET = 8'd16;

endpackage

//--- hdl/ppu_cfg_decode.sv
module ppu_cfg_decode
  import ppu_pkg::*;
(
  input  logic                  VCLK_Tx,
  input  logic                  nVRST_Tx,

  input  cfg_word_t             cfg_word_i,
  input  logic                  interlaced_i,  // Source is 480i

  output logic                  sl_en_o,
  output logic [SL_STR_W-1:0]   sl_str_o,
  output logic [SL_THICK_W-1:0] sl_thick_o,
  output logic                  limited_en_o
);

  // Raw fields
  logic [CFG_VSCALE_W-1:0]    vscale;
  logic [CFG_SL240_STR_W-1:0] str_240p;
  logic [CFG_SL480_STR_W-1:0] str_480i;
  logic                       en_240p;
  logic                       en_480i;
  logic                       link_480i;
  logic                       limited_en;

  // Selected and derived settings
  logic [CFG_SL240_STR_W-1:0] str_sel;
  logic                       en_sel;
  logic [SL_STR_W-1:0]        str_exp;
  logic [SL_THICK_W-1:0]      thick;

  // ========================================
  // Field extraction
  // ========================================

  assign vscale     = cfg_word_i[CFG_VSCALE_LSB +: CFG_VSCALE_W];
  assign str_240p   = cfg_word_i[CFG_SL240_STR_LSB +: CFG_SL240_STR_W];
  assign str_480i   = cfg_word_i[CFG_SL480_STR_LSB +: CFG_SL480_STR_W];
  assign en_240p    = cfg_word_i[CFG_SL240_EN_LSB +: CFG_SL240_EN_W];
  assign en_480i    = cfg_word_i[CFG_SL480_EN_LSB +: CFG_SL480_EN_W];
  assign link_480i  = cfg_word_i[CFG_SL480_LINK_LSB +: CFG_SL480_LINK_W];
  assign limited_en = cfg_word_i[CFG_LIMRGB_LSB +: CFG_LIMRGB_W];

  // ========================================
  // 240p / 480i selection
  // ========================================

  always_comb begin
    if (!interlaced_i) begin
      en_sel  = en_240p;
      str_sel = str_240p;
    end else begin
      en_sel  = en_480i;                       // Enable is always the 480i one
      if (link_480i)
        str_sel = str_240p;                    // Linked to 240p strength
      else
        str_sel = str_480i;
    end
  end

  // 4-bit step expands to 8-bit strength 15..255
  assign str_exp = SL_STR_W'(((str_sel + 1) << 4) - 1);

  // Thicker scanlines for larger vertical scale
  always_comb begin
    if (vscale < VSCALE_THIN_MAX)
      thick = 2'd0;
    else if (vscale < VSCALE_MID_MAX)
      thick = 2'd1;
    else
      thick = 2'd2;
  end

  // ========================================
  // Output registers
  // ========================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      sl_en_o      <= 1'b0;
      sl_str_o     <= '0;
      sl_thick_o   <= '0;
      limited_en_o <= 1'b0;
    end else begin
      sl_en_o      <= en_sel;
      sl_str_o     <= str_exp;
      sl_thick_o   <= thick;
      limited_en_o <= limited_en;
    end
  end

  // Thickness encoding 3 is unused
  a_thick_legal: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    1'b1 |=> (sl_thick_o != 2'd3));

endmodule

//--- hdl/scanline_emu.sv
module scanline_emu
  import ppu_pkg::*;
#(
  parameter int COLOR_W = 8
) (
  input  logic                  VCLK_Tx,
  input  logic                  nVRST_Tx,

  // Scaled pixel stream
  input  logic                  vsync_i,
  input  logic                  hsync_i,
  input  logic                  de_i,
  input  logic [COLOR_W-1:0]    red_i,
  input  logic [COLOR_W-1:0]    green_i,
  input  logic [COLOR_W-1:0]    blue_i,
  input  logic [2:0]            drawsl_i,    // Row within source line, 0 at bottom

  // Settings from decode
  input  logic                  sl_en_i,
  input  logic [SL_STR_W-1:0]   sl_str_i,
  input  logic [SL_THICK_W-1:0] sl_thick_i,

  output logic                  vsync_o,
  output logic                  hsync_o,
  output logic                  de_o,
  output logic [COLOR_W-1:0]    red_o,
  output logic [COLOR_W-1:0]    green_o,
  output logic [COLOR_W-1:0]    blue_o
);

  localparam int PROD_W = COLOR_W + SL_STR_W;

  logic [COLOR_W-1:0] col_in  [0:2];       // R, G, B
  logic [PROD_W-1:0]  prod_s1 [0:2];       // c * strength
  logic [COLOR_W-1:0] col_s1  [0:2];       // Pixel delayed for stage 2
  logic [COLOR_W-1:0] col_q   [0:2];       // Final colors
  logic               darken_s1;
  logic [2:0]         sync_s1;             // {vsync, hsync, de}
  logic [2:0]         sync_q;

  assign col_in[0] = red_i;
  assign col_in[1] = green_i;
  assign col_in[2] = blue_i;

  // ========================================
  // Stage 1, products and darken flag
  // ========================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      for (int i = 0; i < 3; i++) begin
        prod_s1[i] <= '0;
        col_s1[i]  <= '0;
      end
      darken_s1 <= 1'b0;
      sync_s1   <= 3'b000;
    end else begin
      for (int i = 0; i < 3; i++) begin
        prod_s1[i] <= col_in[i] * sl_str_i;   // Full width product
        col_s1[i]  <= col_in[i];
      end
      darken_s1 <= sl_en_i && (drawsl_i <= {1'b0, sl_thick_i});  // Bottom rows only
      sync_s1   <= {vsync_i, hsync_i, de_i};
    end
  end

  // ========================================
  // Stage 2, subtract scaled share
  // ========================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      for (int i = 0; i < 3; i++)
        col_q[i] <= '0;
      sync_q <= 3'b000;
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (darken_s1)
          col_q[i] <= col_s1[i] - COLOR_W'(prod_s1[i][COLOR_W +: SL_STR_W]);  // c - (c*s >> W)
        else
          col_q[i] <= col_s1[i];
      end
      sync_q <= sync_s1;
    end
  end

  assign {vsync_o, hsync_o, de_o} = sync_q;
  assign red_o   = col_q[0];
  assign green_o = col_q[1];
  assign blue_o  = col_q[2];

  // Darkening only ever lowers a color, checked against the input two cycles back
  for (genvar g = 0; g < 3; g++) begin : g_chk
    a_no_brighten: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
      col_q[g] <= $past(col_in[g], 2));
  end

endmodule

//--- hdl/rgb_limiter.sv
module rgb_limiter
  import ppu_pkg::*;
#(
  parameter int COLOR_W = 8
) (
  input  logic               VCLK_Tx,
  input  logic               nVRST_Tx,

  input  logic               vsync_i,
  input  logic               hsync_i,
  input  logic               de_i,
  input  logic [COLOR_W-1:0] red_i,
  input  logic [COLOR_W-1:0] green_i,
  input  logic [COLOR_W-1:0] blue_i,
  input  logic               limited_en_i,  // Taken at the output register

  output logic               vsync_o,
  output logic               hsync_o,
  output logic               de_o,
  output logic [COLOR_W-1:0] red_o,
  output logic [COLOR_W-1:0] green_o,
  output logic [COLOR_W-1:0] blue_o
);

  localparam int PROD_W = COLOR_W + 8;      // Color times 8-bit coefficient
  localparam int SHIFT  = COLOR_W - 8;      // Offsets follow the color width

  // Limited range bounds at this color width
  localparam logic [COLOR_W-1:0] LIM_LO = COLOR_W'(LIMIT_OFFSET) << SHIFT;
  localparam logic [COLOR_W-1:0] LIM_HI =
    COLOR_W'(((LIMIT_OFFSET + LIMIT_COEFF) << SHIFT) - 1);

  logic [COLOR_W-1:0] col_in  [0:2];
  logic [PROD_W-1:0]  prod    [0:2];
  logic [COLOR_W:0]   lim_s1  [0:2];        // Upper W+1 bits, one extra for rounding
  logic [COLOR_W-1:0] lim_s2  [0:2];        // Rounded scaled color
  logic [COLOR_W-1:0] full_s1 [0:2];        // Full range pixel ride-along
  logic [COLOR_W-1:0] full_s2 [0:2];
  logic [COLOR_W-1:0] col_q   [0:2];
  logic [2:0]         sync_s1;              // {vsync, hsync, de}
  logic [2:0]         sync_s2;
  logic [2:0]         sync_q;

  assign col_in[0] = red_i;
  assign col_in[1] = green_i;
  assign col_in[2] = blue_i;

  always_comb begin
    for (int i = 0; i < 3; i++)
      prod[i] = col_in[i] * LIMIT_COEFF;
  end

  // ========================================
  // Three-stage limiter pipeline
  // ========================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      for (int i = 0; i < 3; i++) begin
        lim_s1[i]  <= '0;
        lim_s2[i]  <= '0;
        full_s1[i] <= '0;
        full_s2[i] <= '0;
        col_q[i]   <= '0;
      end
      sync_s1 <= 3'b000;
      sync_s2 <= 3'b000;
      sync_q  <= 3'b000;
    end else begin
      for (int i = 0; i < 3; i++) begin
        lim_s1[i]  <= prod[i][PROD_W-1 -: COLOR_W+1];        // c*220 >> 7
        lim_s2[i]  <= lim_s1[i][COLOR_W:1] + lim_s1[i][0];   // Round half up
        full_s1[i] <= col_in[i];
        full_s2[i] <= full_s1[i];
        if (limited_en_i)
          col_q[i] <= lim_s2[i] + LIM_LO;                    // Lift by 16
        else
          col_q[i] <= full_s2[i];
      end
      sync_s1 <= {vsync_i, hsync_i, de_i};
      sync_s2 <= sync_s1;
      sync_q  <= sync_s2;
    end
  end

  assign {vsync_o, hsync_o, de_o} = sync_q;
  assign red_o   = col_q[0];
  assign green_o = col_q[1];
  assign blue_o  = col_q[2];

  // A color selected in limited mode stays inside 16..235
  for (genvar g = 0; g < 3; g++) begin : g_chk
    a_in_range: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
      $past(limited_en_i) |-> (col_q[g] >= LIM_LO) && (col_q[g] <= LIM_HI));
  end

endmodule

//--- hdl/ppu_out_top.sv
module ppu_out_top
  import ppu_pkg::*;
#(
  parameter int COLOR_W = 8
) (
  input  logic               VCLK_Tx,
  input  logic               nVRST_Tx,

  // Static configuration
  input  cfg_word_t          cfg_word_i,
  input  logic               interlaced_i,

  // Scaled pixel stream
  input  logic               vsync_i,
  input  logic               hsync_i,
  input  logic               de_i,
  input  logic [COLOR_W-1:0] red_i,
  input  logic [COLOR_W-1:0] green_i,
  input  logic [COLOR_W-1:0] blue_i,
  input  logic [2:0]         drawsl_i,

  // To transmitter, 5 cycles after input
  output logic               vsync_o,
  output logic               hsync_o,
  output logic               de_o,
  output logic [COLOR_W-1:0] red_o,
  output logic [COLOR_W-1:0] green_o,
  output logic [COLOR_W-1:0] blue_o
);

  // Decoded settings
  logic                  sl_en_w;
  logic [SL_STR_W-1:0]   sl_str_w;
  logic [SL_THICK_W-1:0] sl_thick_w;
  logic                  limited_en_w;

  // Scanline to limiter
  logic                  vsync_sl_w, hsync_sl_w, de_sl_w;
  logic [COLOR_W-1:0]    red_sl_w, green_sl_w, blue_sl_w;

  // ========================================
  // Configuration
  // ========================================

  ppu_cfg_decode cfg_decode_u (
    .VCLK_Tx      (VCLK_Tx),
    .nVRST_Tx     (nVRST_Tx),
    .cfg_word_i   (cfg_word_i),
    .interlaced_i (interlaced_i),
    .sl_en_o      (sl_en_w),
    .sl_str_o     (sl_str_w),
    .sl_thick_o   (sl_thick_w),
    .limited_en_o (limited_en_w)
  );

  // ========================================
  // Scanlines, 2 cycles
  // ========================================

  scanline_emu #(
    .COLOR_W (COLOR_W)
  ) scanline_emu_u (
    .VCLK_Tx    (VCLK_Tx),
    .nVRST_Tx   (nVRST_Tx),
    .vsync_i    (vsync_i),
    .hsync_i    (hsync_i),
    .de_i       (de_i),
    .red_i      (red_i),
    .green_i    (green_i),
    .blue_i     (blue_i),
    .drawsl_i   (drawsl_i),
    .sl_en_i    (sl_en_w),
    .sl_str_i   (sl_str_w),
    .sl_thick_i (sl_thick_w),
    .vsync_o    (vsync_sl_w),
    .hsync_o    (hsync_sl_w),
    .de_o       (de_sl_w),
    .red_o      (red_sl_w),
    .green_o    (green_sl_w),
    .blue_o     (blue_sl_w)
  );

  // ========================================
  // Limited RGB and final outputs, 3 cycles
  // ========================================

  rgb_limiter #(
    .COLOR_W (COLOR_W)
  ) rgb_limiter_u (
    .VCLK_Tx      (VCLK_Tx),
    .nVRST_Tx     (nVRST_Tx),
    .vsync_i      (vsync_sl_w),
    .hsync_i      (hsync_sl_w),
    .de_i         (de_sl_w),
    .red_i        (red_sl_w),
    .green_i      (green_sl_w),
    .blue_i       (blue_sl_w),
    .limited_en_i (limited_en_w),
    .vsync_o      (vsync_o),
    .hsync_o      (hsync_o),
    .de_o         (de_o),
    .red_o        (red_o),
    .green_o      (green_o),
    .blue_o       (blue_o)
  );

endmodule

//--- tb/tb_ppu_out_top.sv
module tb_ppu_out_top
  import ppu_pkg::*;
();

  localparam int PHASE_PIX  = 300;                       // Pixels per phase
  localparam int NUM_PHASES = 5;
  localparam int MAX_CYCLES = NUM_PHASES * PHASE_PIX + 500;  // Reset, settling and flush margin

  // Expected output word with vld clear while a config change settles
  typedef struct packed {
    logic       vld;
    logic       vs;
    logic       hs;
    logic       de;
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } exp_t;

  logic       VCLK_Tx;
  logic       nVRST_Tx;
  cfg_word_t  cfg_word;
  logic       interlaced;
  logic       vsync_in, hsync_in, de_in;
  logic [7:0] red_in, green_in, blue_in;
  logic [2:0] drawsl;
  logic       vsync_out, hsync_out, de_out;
  logic [7:0] red_out, green_out, blue_out;

  exp_t       exp_q[$];                                  // Pixels in flight
  exp_t       exp_cur;                                   // Due at the outputs now
  cfg_word_t  mdl_cfg;                                   // Model copy of the config
  logic       mdl_il;
  int         skip_cnt;
  int         n_checked;
  int         cycle_cnt;
  logic [31:0] rnd;

  ppu_out_top #(
    .COLOR_W (8)
  ) ppu_out_top_inst (
    .VCLK_Tx      (VCLK_Tx),
    .nVRST_Tx     (nVRST_Tx),
    .cfg_word_i   (cfg_word),
    .interlaced_i (interlaced),
    .vsync_i      (vsync_in),
    .hsync_i      (hsync_in),
    .de_i         (de_in),
    .red_i        (red_in),
    .green_i      (green_in),
    .blue_i       (blue_in),
    .drawsl_i     (drawsl),
    .vsync_o      (vsync_out),
    .hsync_o      (hsync_out),
    .de_o         (de_out),
    .red_o        (red_out),
    .green_o      (green_out),
    .blue_o       (blue_out)
  );

  initial begin
    VCLK_Tx = 1'b0;
    forever #5 VCLK_Tx = ~VCLK_Tx;
  end

  // ========================================
  // Reference model
  // ========================================

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Pack the config word fields
  function automatic cfg_word_t make_cfg(input logic [4:0] vscale, input logic [3:0] s240,
                                         input logic en240, input logic [3:0] s480,
                                         input logic en480, input logic link, input logic lim);
    return {lim, link, en480, s480, en240, s240, vscale};
  endfunction

  function automatic logic [1:0] thickness(input logic [4:0] vscale);
    if (vscale < 5'd6)
      return 2'd0;
    else if (vscale < 5'd14)
      return 2'd1;
    return 2'd2;
  endfunction

  function automatic logic [7:0] expect_color(input logic [7:0] c, input logic dark,
                                              input logic [7:0] str, input logic lim);
    logic [15:0] p;
    logic [15:0] q;
    logic [7:0]  v;
    v = c;
    if (dark) begin
      p = 16'(c) * 16'(str);
      v = c - p[15:8];                                   // c - (c*s >> 8)
    end
    if (lim) begin
      q = (16'(v) * 16'd220) >> 7;
      q = (q + 16'd1) >> 1;                              // Rounded c*220/256
      v = q[7:0] + 8'd16;
    end
    return v;
  endfunction

  // ========================================
  // Stimulus tasks
  // ========================================

  // One pixel per rising edge with its expected result queued alongside
  task automatic drive_cycle(input logic vs, input logic hs, input logic de,
                             input logic [7:0] r, input logic [7:0] g, input logic [7:0] b,
                             input logic [2:0] dsl);
    exp_t       e;
    logic [3:0] str_field;
    logic [8:0] str_w;
    logic       sl_en;
    logic       dark;
    @(posedge VCLK_Tx);
    vsync_in <= vs;
    hsync_in <= hs;
    de_in    <= de;
    red_in   <= r;
    green_in <= g;
    blue_in  <= b;
    drawsl   <= dsl;
    if (!mdl_il) begin
      sl_en     = mdl_cfg[9];
      str_field = mdl_cfg[8:5];
    end else begin
      sl_en     = mdl_cfg[14];                             // 480i enable
      str_field = mdl_cfg[15] ? mdl_cfg[8:5] : mdl_cfg[13:10];
    end
    str_w = (9'(str_field) + 9'd1) * 9'd16 - 9'd1;
    dark  = sl_en && ({1'b0, thickness(mdl_cfg[4:0])} >= dsl);
    e.vld = (skip_cnt == 0);
    if (skip_cnt > 0)
      skip_cnt--;
    e.vs = vs;
    e.hs = hs;
    e.de = de;
    e.r  = expect_color(r, dark, str_w[7:0], mdl_cfg[16]);
    e.g  = expect_color(g, dark, str_w[7:0], mdl_cfg[16]);
    e.b  = expect_color(b, dark, str_w[7:0], mdl_cfg[16]);
    exp_q.push_back(e);
    if (exp_q.size() > 5)
      exp_cur = exp_q.pop_front();                       // 5 cycles of latency
  endtask

  task automatic drive_random(input int n, input logic extremes);
    logic [7:0] r, g, b;
    logic [2:0] dsl;
    logic [2:0] sy;
    for (int i = 0; i < n; i++) begin
      rnd = lcg_next(rnd);
      r   = rnd[31:24];
      g   = rnd[23:16];
      b   = rnd[15:8];
      rnd = lcg_next(rnd);
      dsl = rnd[30:28];
      sy  = rnd[27:25];
      if (extremes && (i % 4 == 0)) begin                // Range end points
        r = 8'h00;
        g = 8'hFF;
        b = i[2] ? 8'hFF : 8'h00;
      end
      drive_cycle(sy[2], sy[1], sy[0], r, g, b, dsl);
    end
  endtask

  // Pixels still in flight see a mix of old and new settings
  task automatic set_config(input cfg_word_t w, input logic il);
    exp_t e;
    for (int i = 0; i < exp_q.size(); i++) begin
      e        = exp_q[i];
      e.vld    = 1'b0;
      exp_q[i] = e;
    end
    cfg_word   <= w;
    interlaced <= il;
    mdl_cfg    = w;
    mdl_il     = il;
    skip_cnt   = 2;                                      // Decoder register settles
  endtask

  // ========================================
  // Output checks
  // ========================================

  a_sync_match: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    !exp_cur.vld || ({vsync_out, hsync_out, de_out} == {exp_cur.vs, exp_cur.hs, exp_cur.de}))
    else begin
      $display("Error at %0t: sync mismatch, expected %b%b%b got %b%b%b", $time,
               $sampled(exp_cur.vs), $sampled(exp_cur.hs), $sampled(exp_cur.de),
               $sampled(vsync_out), $sampled(hsync_out), $sampled(de_out));
      $display("Result: FAILED");
      $fatal(1, "sync check failed");
    end

  a_color_match: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    !exp_cur.vld || ({red_out, green_out, blue_out} == {exp_cur.r, exp_cur.g, exp_cur.b}))
    n_checked = n_checked + 1;
    else begin
      $display("Error at %0t: color mismatch, expected %h %h %h got %h %h %h", $time,
               $sampled(exp_cur.r), $sampled(exp_cur.g), $sampled(exp_cur.b),
               $sampled(red_out), $sampled(green_out), $sampled(blue_out));
      $display("Result: FAILED");
      $fatal(1, "color check failed");
    end

  always @(posedge VCLK_Tx) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
  end

  // ========================================
  // Test sequence
  // ========================================

  initial begin
    nVRST_Tx   <= 1'b0;
    cfg_word   <= '0;
    interlaced <= 1'b0;
    vsync_in   <= 1'b0;
    hsync_in   <= 1'b0;
    de_in      <= 1'b0;
    red_in     <= '0;
    green_in   <= '0;
    blue_in    <= '0;
    drawsl     <= '0;
    mdl_cfg    = '0;
    mdl_il     = 1'b0;
    skip_cnt   = 0;
    n_checked  = 0;
    rnd        = 32'd91858;
    exp_cur    = '0;
    exp_cur.vld = 1'b1;                                  // Outputs start at zero
    repeat (5)
      drive_cycle(1'b0, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00, 3'd0);
    nVRST_Tx <= 1'b1;

    // Everything off gives a plain 5-cycle delay
    drive_random(PHASE_PIX, 1'b0);

    // 240p scanlines at thickness 0, 1 and 2
    set_config(make_cfg(5'd3, 4'd5, 1'b1, 4'd12, 1'b0, 1'b0, 1'b0), 1'b0);
    drive_random(PHASE_PIX / 3, 1'b0);
    set_config(make_cfg(5'd10, 4'd15, 1'b1, 4'd2, 1'b1, 1'b0, 1'b0), 1'b0);
    drive_random(PHASE_PIX / 3, 1'b0);
    set_config(make_cfg(5'd20, 4'd0, 1'b1, 4'd7, 1'b0, 1'b1, 1'b0), 1'b0);
    drive_random(PHASE_PIX / 3, 1'b0);

    // 480i own strength, then linked, then 480i disabled
    set_config(make_cfg(5'd12, 4'd2, 1'b0, 4'd9, 1'b1, 1'b0, 1'b0), 1'b1);
    drive_random(PHASE_PIX / 3, 1'b0);
    set_config(make_cfg(5'd12, 4'd2, 1'b0, 4'd9, 1'b1, 1'b1, 1'b0), 1'b1);
    drive_random(PHASE_PIX / 3, 1'b0);
    set_config(make_cfg(5'd12, 4'd2, 1'b1, 4'd9, 1'b0, 1'b0, 1'b0), 1'b1);
    drive_random(PHASE_PIX / 3, 1'b0);

    // Limited RGB alone with 0 and 255 mixed in
    set_config(make_cfg(5'd8, 4'd4, 1'b0, 4'd4, 1'b0, 1'b0, 1'b1), 1'b0);
    drive_random(PHASE_PIX, 1'b1);

    // Scanlines and limiting together
    set_config(make_cfg(5'd16, 4'd7, 1'b1, 4'd3, 1'b0, 1'b0, 1'b1), 1'b0);
    drive_random(PHASE_PIX / 2, 1'b1);
    set_config(make_cfg(5'd4, 4'd11, 1'b0, 4'd3, 1'b1, 1'b1, 1'b1), 1'b1);
    drive_random(PHASE_PIX / 2, 1'b1);

    // Drain the pipeline
    repeat (8)
      drive_cycle(1'b0, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00, 3'd0);

    if (n_checked > NUM_PHASES * PHASE_PIX) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("Only %0d output checks ran, fewer than the pixels driven", n_checked);
      $display("Result: FAILED");
      $fatal(1, "too few checks");
    end
  end

endmodule

//--- compile.f
hdl/ppu_pkg.sv
hdl/ppu_cfg_decode.sv
hdl/scanline_emu.sv
hdl/rgb_limiter.sv
hdl/ppu_out_top.sv
tb/tb_ppu_out_top.sv
